//--- cache2way.f
+incdir+src
src/cache_pkg.sv
src/cache_ctrl.sv
src/cache_tag_array.sv
src/cache_data_path.sv
src/cache_top.sv
sim/cache_assert.sv
sim/cache_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cache_tb
FILELIST  ?= cache2way.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "Simulation FAILED: no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/cache_tb.sv
/* Testbench for the two-way cache: clock, reset, memory model,
   directed and random stimulus, reference model, checker, watchdog */

`timescale 1ns/100ps
`default_nettype none

`include "cache_cfg.svh"

module cache_tb;
  import cache_pkg::*;

  localparam int NUM_REQS = 311;
  localparam logic [31:0] SEED = 32'hf24c;

  logic                     clk = 1'b0;
  logic                     reset = 1'b1;
  logic                     req_val = 1'b0;
  logic                     req_rdy;
  mem_op_t                  req_type = OP_READ;
  logic [`CACHE_ADDR_W-1:0] req_addr = '0;
  logic [`CACHE_DATA_W-1:0] req_data = '0;
  logic                     resp_val;
  logic                     resp_rdy = 1'b0;
  mem_op_t                  resp_type;
  logic [`CACHE_DATA_W-1:0] resp_data;
  logic                     mem_req_val;
  logic                     mem_req_rdy = 1'b0;
  mem_op_t                  mem_req_type;
  logic [`CACHE_ADDR_W-1:0] mem_req_addr;
  logic [`CACHE_DATA_W-1:0] mem_req_data;
  logic                     mem_resp_val = 1'b0;
  logic                     mem_resp_rdy;
  logic [`CACHE_DATA_W-1:0] mem_resp_data = '0;

  // Reference state of the processor view
  logic [31:0] shadow [64];
  logic        touched [64];
  logic [31:0] mem_model [64];

  mem_op_t     exp_type = OP_READ;
  logic [31:0] exp_data = '0;
  logic        backpressure = 1'b0;
  int          cycle = 0;
  int          resp_count = 0;
  int          resp_edge = 0;
  int          cmp_errors = 0;
  int          mem_errors = 0;
  int          stim_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          last_latency = 0;

  // Memory model bookkeeping
  logic [31:0] mem_rng = SEED;
  logic [31:0] bp_rng = SEED ^ 32'h0000_1357;
  logic [31:0] stim_rng = SEED ^ 32'h0002_468a;
  logic        loaded = 1'b0;
  logic        mem_busy = 1'b0;
  logic        mem_is_wr = 1'b0;
  logic [1:0]  mem_delay = '0;
  logic [5:0]  mem_word = '0;
  int          rd_cnt = 0;
  int          wr_cnt = 0;
  int          wb_checked = 0;
  int          val_cycles = 0;
  logic [5:0]  last_rd_word = '0;
  logic [5:0]  last_wr_word = '0;
  logic [31:0] last_wr_data = '0;

  cache_top dut (.*);

  bind cache_top cache_assert chk (
    .clk(clk), .reset(reset), .req_rdy(req_rdy), .resp_val(resp_val),
    .resp_rdy(resp_rdy), .resp_type(resp_type), .resp_data(resp_data),
    .mem_req_val(mem_req_val), .mem_req_rdy(mem_req_rdy),
    .mem_req_type(mem_req_type), .mem_req_addr(mem_req_addr),
    .mem_req_data(mem_req_data)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // ----------------------------------------
  // Helpers and reference model
  // ----------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Preload value of a never-touched word
  function automatic logic [31:0] fill_pattern(input logic [5:0] word);
    return {word, word, word, word, 8'hc3};
  endfunction

  function automatic logic [31:0] ref_value(input logic [5:0] word);
    return touched[word] ? shadow[word] : fill_pattern(word);
  endfunction

  function automatic int total_errors();
    return cmp_errors + mem_errors + stim_errors;
  endfunction

  // ----------------------------------------
  // Memory model
  // ----------------------------------------
  always @(posedge clk) begin
    mem_rng <= xorshift(mem_rng);
    if (!loaded) begin
      for (int i = 0; i < 64; i++) begin
        mem_model[i] <= fill_pattern(6'(i));
      end
      loaded <= 1'b1;
    end
    if (reset) begin
      mem_req_rdy  <= 1'b0;
      mem_resp_val <= 1'b0;
      mem_busy     <= 1'b0;
    end else begin
      if (mem_req_val) val_cycles <= val_cycles + 1;
      // Init fills the cache only, so the backing store takes it here
      if (req_val && req_rdy && req_type == OP_INIT) begin
        mem_model[req_addr[7:2]] <= req_data;
      end
      if (mem_resp_val && mem_resp_rdy) begin
        mem_resp_val <= 1'b0;
        mem_busy     <= 1'b0;
      end else if (mem_busy && !mem_resp_val) begin
        if (mem_delay == 2'd0) begin
          mem_resp_val  <= 1'b1;
          mem_resp_data <= mem_is_wr ? 32'd0 : mem_model[mem_word];
        end else begin
          mem_delay <= mem_delay - 2'd1;
        end
      end
      if (mem_req_val && mem_req_rdy) begin
        mem_busy    <= 1'b1;
        mem_req_rdy <= 1'b0;
        mem_word    <= mem_req_addr[7:2];
        mem_delay   <= 2'(mem_rng % 3);
        mem_is_wr   <= (mem_req_type == OP_WRITE);
        if (mem_req_type == OP_WRITE) begin
          mem_model[mem_req_addr[7:2]] <= mem_req_data;
          wr_cnt       <= wr_cnt + 1;
          last_wr_word <= mem_req_addr[7:2];
          last_wr_data <= mem_req_data;
          wb_checked   <= wb_checked + 1;
          assert (mem_req_data == ref_value(mem_req_addr[7:2])) else begin
            $display("ERROR at %0t: mem_req_data got %h expected %h", $time,
                     mem_req_data, ref_value(mem_req_addr[7:2]));
            mem_errors++;
          end
        end else begin
          rd_cnt       <= rd_cnt + 1;
          last_rd_word <= mem_req_addr[7:2];
        end
      end else if (!mem_busy) begin
        mem_req_rdy <= (mem_rng[2:0] != 3'd0);
      end
    end
  end

  // Random back-pressure on the response channel
  always @(posedge clk) begin
    bp_rng   <= xorshift(bp_rng);
    resp_rdy <= !backpressure || (bp_rng[1:0] != 2'd0);
  end

  // ----------------------------------------
  // Response checker
  // ----------------------------------------
  always @(negedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      assert (resp_type == exp_type) else begin
        $display("ERROR at %0t: resp_type got %0d expected %0d", $time, resp_type, exp_type);
        cmp_errors++;
      end
      assert (resp_data == exp_data) else begin
        $display("ERROR at %0t: resp_data got %h expected %h", $time, resp_data, exp_data);
        cmp_errors++;
      end
      resp_edge  <= cycle + 1;
      resp_count <= resp_count + 1;
    end
  end

  // ----------------------------------------
  // Stimulus tasks
  // ----------------------------------------
  task automatic issue(input mem_op_t op, input logic [5:0] word, input logic [31:0] data);
    int start_count;
    int acc_edge;
    exp_type = op;
    exp_data = (op == OP_READ) ? ref_value(word) : 32'd0;
    if (op != OP_READ) begin
      shadow[word]  = data;
      touched[word] = 1'b1;
    end
    start_count = resp_count;
    @(posedge clk);
    req_val  <= 1'b1;
    req_type <= op;
    req_addr <= {24'd0, word, 2'b00};
    req_data <= data;
    do @(negedge clk); while (!req_rdy);
    acc_edge = cycle + 1;
    @(posedge clk);
    req_val <= 1'b0;
    while (resp_count == start_count) @(posedge clk);
    last_latency = resp_edge - acc_edge;
  endtask

  task automatic check_val(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("ERROR at %0t: %s got %0h expected %0h", $time, name, got, exp);
      stim_errors++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (total_errors() == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAIL", tests_run, name);
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    int errs;
    int vc;
    int rc;
    int wc;
    logic [5:0] word;
    mem_op_t op;
    for (int i = 0; i < 64; i++) begin
      touched[i] = 1'b0;
      shadow[i]  = '0;
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // Init then read back
    errs = total_errors();
    vc = val_cycles;
    issue(OP_INIT, 6'd1, 32'h1111_abcd);
    issue(OP_READ, 6'd1, 32'd0);
    check_val("read latency", last_latency, 3);
    check_val("mem_req_val cycles", val_cycles - vc, 0);
    end_test("init then read", errs);

    // Read miss then read hit
    errs = total_errors();
    rc = rd_cnt;
    wc = wr_cnt;
    issue(OP_READ, 6'd2, 32'd0);
    check_val("memory reads", rd_cnt - rc, 1);
    check_val("memory read word", int'(last_rd_word), 2);
    check_val("memory writes", wr_cnt - wc, 0);
    vc = val_cycles;
    issue(OP_READ, 6'd2, 32'd0);
    check_val("mem_req_val cycles", val_cycles - vc, 0);
    end_test("read miss and hit", errs);

    // Write hit then read
    errs = total_errors();
    vc = val_cycles;
    issue(OP_WRITE, 6'd1, 32'h2222_5678);
    issue(OP_READ, 6'd1, 32'd0);
    check_val("mem_req_val cycles", val_cycles - vc, 0);
    end_test("write hit", errs);

    // Dirty eviction in set 5
    errs = total_errors();
    issue(OP_WRITE, 6'd5, 32'haaaa_0005);
    issue(OP_WRITE, 6'd13, 32'hbbbb_000d);
    issue(OP_READ, 6'd5, 32'd0);
    rc = rd_cnt;
    wc = wr_cnt;
    issue(OP_READ, 6'd21, 32'd0);
    check_val("memory writes", wr_cnt - wc, 1);
    check_val("write-back word", int'(last_wr_word), 13);
    check_val("write-back data", last_wr_data, 32'hbbbb_000d);
    check_val("memory reads", rd_cnt - rc, 1);
    check_val("refill word", int'(last_rd_word), 21);
    vc = val_cycles;
    issue(OP_READ, 6'd5, 32'd0);
    check_val("mem_req_val cycles", val_cycles - vc, 0);
    end_test("dirty eviction", errs);

    // Random mix from an empty cache, processor view resynced to memory
    errs = total_errors();
    @(posedge clk);
    reset <= 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    for (int i = 0; i < 64; i++) begin
      shadow[i]  = mem_model[i];
      touched[i] = 1'b1;
    end
    backpressure = 1'b1;
    wc = wb_checked;
    for (int i = 0; i < 300; i++) begin
      stim_rng = xorshift(stim_rng);
      word = stim_rng[5:0];
      // Inits only while no line is dirty
      if (i < 60) begin
        op = stim_rng[8] ? OP_INIT : OP_READ;
      end else begin
        op = stim_rng[8] ? OP_WRITE : OP_READ;
      end
      issue(op, word, {stim_rng[15:0], stim_rng[31:16]});
    end
    backpressure = 1'b0;
    assert (wb_checked != wc) else begin
      $display("No write-back happened during the random mix");
      stim_errors++;
    end
    end_test("random mix", errs);

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
             total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog, 200 cycles per request
  initial begin
    repeat (200 * NUM_REQS) @(posedge clk);
    $display("Timeout: run did not end within %0d cycles", 200 * NUM_REQS);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/cache_assert.sv
/* Bound checker for the cache ports: handshake hold, ready/response
   exclusion and reset values */

`timescale 1ns/100ps
`default_nettype none

module cache_assert (
  input logic               clk,
  input logic               reset,
  input logic               req_rdy,
  input logic               resp_val,
  input logic               resp_rdy,
  input cache_pkg::mem_op_t resp_type,
  input logic [31:0]        resp_data,
  input logic               mem_req_val,
  input logic               mem_req_rdy,
  input cache_pkg::mem_op_t mem_req_type,
  input logic [31:0]        mem_req_addr,
  input logic [31:0]        mem_req_data
);

  // Response held until the processor takes it
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_data) && $stable(resp_type))
    else $error("resp_val or response fields changed before resp_rdy");

  // Memory request held until the memory takes it
  a_mem_hold: assert property (@(posedge clk) disable iff (reset)
    mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req_addr)
      && $stable(mem_req_data) && $stable(mem_req_type))
    else $error("mem_req_val or request fields changed before mem_req_rdy");

  a_rdy_excl: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> !req_rdy)
    else $error("req_rdy high while resp_val is high");

  a_reset_vals: assert property (@(posedge clk)
    reset |=> !resp_val && !mem_req_val)
    else $error("resp_val or mem_req_val high after reset");

endmodule

`default_nettype wire

//--- src/cache_top.sv
/* Two-way write-back data cache: controller, tag array and
   data path joined to the processor and memory ports */

`timescale 1ns/100ps
`default_nettype none

`include "cache_cfg.svh"

module cache_top (
  input  logic                     clk,
  input  logic                     reset,
  // Processor side
  input  logic                     req_val,
  output logic                     req_rdy,
  input  cache_pkg::mem_op_t       req_type,
  input  logic [`CACHE_ADDR_W-1:0] req_addr,
  input  logic [`CACHE_DATA_W-1:0] req_data,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output cache_pkg::mem_op_t       resp_type,
  output logic [`CACHE_DATA_W-1:0] resp_data,
  // Memory side
  output logic                     mem_req_val,
  input  logic                     mem_req_rdy,
  output cache_pkg::mem_op_t       mem_req_type,
  output logic [`CACHE_ADDR_W-1:0] mem_req_addr,
  output logic [`CACHE_DATA_W-1:0] mem_req_data,
  input  logic                     mem_resp_val,
  output logic                     mem_resp_rdy,
  input  logic [`CACHE_DATA_W-1:0] mem_resp_data
);
  import cache_pkg::*;

  mem_op_t                   cur_type;
  logic [`CACHE_INDEX_W-1:0] req_index;
  logic [`CACHE_TAG_W-1:0]   req_tag;
  logic [`CACHE_TAG_W-1:0]   victim_tag;
  logic hit_0, hit_1, dirty_0, dirty_1, lru;
  logic req_en, tag_write, dirty_in, lru_write, lru_in, way;
  logic data_read, data_write, fill_from_mem, read_capture;
  logic evict_select, resp_zero, mem_write;

  assign mem_req_type = mem_write ? OP_WRITE : OP_READ;
  // Response echoes the kind of the request in flight
  assign resp_type    = cur_type;

  cache_ctrl ctrl (
    .clk           (clk),
    .reset         (reset),
    .req_val       (req_val),
    .req_rdy       (req_rdy),
    .resp_val      (resp_val),
    .resp_rdy      (resp_rdy),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_rdy  (mem_resp_rdy),
    .mem_write     (mem_write),
    .req_type      (cur_type),
    .hit_0         (hit_0),
    .hit_1         (hit_1),
    .dirty_0       (dirty_0),
    .dirty_1       (dirty_1),
    .lru           (lru),
    .req_en        (req_en),
    .tag_write     (tag_write),
    .dirty_in      (dirty_in),
    .lru_write     (lru_write),
    .lru_in        (lru_in),
    .way           (way),
    .data_read     (data_read),
    .data_write    (data_write),
    .fill_from_mem (fill_from_mem),
    .read_capture  (read_capture),
    .evict_select  (evict_select),
    .resp_zero     (resp_zero)
  );

  cache_tag_array tags (
    .clk        (clk),
    .reset      (reset),
    .req_index  (req_index),
    .req_tag    (req_tag),
    .way        (way),
    .tag_write  (tag_write),
    .dirty_in   (dirty_in),
    .lru_write  (lru_write),
    .lru_in     (lru_in),
    .hit_0      (hit_0),
    .hit_1      (hit_1),
    .dirty_0    (dirty_0),
    .dirty_1    (dirty_1),
    .lru        (lru),
    .victim_tag (victim_tag)
  );

  cache_data_path dpath (
    .clk           (clk),
    .reset         (reset),
    .req_en        (req_en),
    .req_type_in   (req_type),
    .req_addr      (req_addr),
    .req_data      (req_data),
    .req_type      (cur_type),
    .req_index     (req_index),
    .req_tag       (req_tag),
    .way           (way),
    .data_read     (data_read),
    .data_write    (data_write),
    .fill_from_mem (fill_from_mem),
    .read_capture  (read_capture),
    .evict_select  (evict_select),
    .resp_zero     (resp_zero),
    .victim_tag    (victim_tag),
    .mem_resp_data (mem_resp_data),
    .resp_data     (resp_data),
    .mem_req_addr  (mem_req_addr),
    .mem_req_data  (mem_req_data)
  );

endmodule

`default_nettype wire

//--- src/cache_data_path.sv
/* Request register, data arrays of both ways, read-data register
   and the memory request address and data */

`timescale 1ns/100ps
`default_nettype none

`include "cache_cfg.svh"

module cache_data_path (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_en,
  input  cache_pkg::mem_op_t        req_type_in,
  input  logic [`CACHE_ADDR_W-1:0]  req_addr,
  input  logic [`CACHE_DATA_W-1:0]  req_data,
  output cache_pkg::mem_op_t        req_type,
  output logic [`CACHE_INDEX_W-1:0] req_index,
  output logic [`CACHE_TAG_W-1:0]   req_tag,
  input  logic                      way,
  input  logic                      data_read,
  input  logic                      data_write,
  input  logic                      fill_from_mem,
  input  logic                      read_capture,
  input  logic                      evict_select,
  input  logic                      resp_zero,
  input  logic [`CACHE_TAG_W-1:0]   victim_tag,
  input  logic [`CACHE_DATA_W-1:0]  mem_resp_data,
  output logic [`CACHE_DATA_W-1:0]  resp_data,
  output logic [`CACHE_ADDR_W-1:0]  mem_req_addr,
  output logic [`CACHE_DATA_W-1:0]  mem_req_data
);
  import cache_pkg::*;

  logic [`CACHE_DATA_W-1:0] req_data_q;
  logic [`CACHE_DATA_W-1:0] data_mem [2][`CACHE_NUM_SETS];
  logic [`CACHE_DATA_W-1:0] rd_word;
  logic [`CACHE_DATA_W-1:0] wr_word;
  logic [`CACHE_DATA_W-1:0] rdata_q;

  // ----------------------------------------
  // Request register
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      req_type <= OP_READ;
    end else if (req_en) begin
      req_type <= req_type_in;
    end
  end

  // Byte offset is dropped, lines are one word
  always_ff @(posedge clk) begin
    if (req_en) begin
      req_tag    <= req_addr[`CACHE_ADDR_W-1:`CACHE_INDEX_W+2];
      req_index  <= req_addr[`CACHE_INDEX_W+1:2];
      req_data_q <= req_data;
    end
  end

  // ----------------------------------------
  // Data arrays
  // ----------------------------------------
  // Refill takes the memory word, init and write take the request word
  assign wr_word = fill_from_mem ? mem_resp_data : req_data_q;

  always_ff @(posedge clk) begin
    if (data_write) begin
      data_mem[way][req_index] <= wr_word;
    end
  end

  assign rd_word = data_read ? data_mem[way][req_index] : '0;

  // Read-data register, loaded at the end of an access or evict prep
  always_ff @(posedge clk) begin
    if (read_capture) begin
      rdata_q <= resp_zero ? '0 : rd_word;
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------
  assign resp_data    = rdata_q;
  // Same register carries the victim word during write-back
  assign mem_req_data = rdata_q;

  assign mem_req_addr = evict_select ? {victim_tag, req_index, 2'b00}
                                     : {req_tag, req_index, 2'b00};

endmodule

`default_nettype wire

//--- src/cache_tag_array.sv
/* Tag, valid and dirty storage for both ways, per-set LRU bits,
   and the tag compare for the current index */

`timescale 1ns/100ps
`default_nettype none

`include "cache_cfg.svh"

module cache_tag_array (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`CACHE_INDEX_W-1:0] req_index,
  input  logic [`CACHE_TAG_W-1:0]   req_tag,
  input  logic                      way,
  input  logic                      tag_write,
  input  logic                      dirty_in,
  input  logic                      lru_write,
  input  logic                      lru_in,
  output logic                      hit_0,
  output logic                      hit_1,
  output logic                      dirty_0,
  output logic                      dirty_1,
  output logic                      lru,
  output logic [`CACHE_TAG_W-1:0]   victim_tag
);

  // Tags per way and set
  logic [`CACHE_TAG_W-1:0] tags [2][`CACHE_NUM_SETS];

  // State bits, way in the outer dimension
  logic [1:0][`CACHE_NUM_SETS-1:0] valid_bits;
  logic [1:0][`CACHE_NUM_SETS-1:0] dirty_bits;
  logic [`CACHE_NUM_SETS-1:0]      lru_bits;

  // ----------------------------------------
  // Writes
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (tag_write) begin
      tags[way][req_index] <= req_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (tag_write) begin
      valid_bits[way][req_index] <= 1'b1;
      dirty_bits[way][req_index] <= dirty_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      lru_bits <= '0;
    end else if (lru_write) begin
      lru_bits[req_index] <= lru_in;
    end
  end

  // ----------------------------------------
  // Combinational lookup
  // ----------------------------------------
  // A match only counts on a valid entry
  assign hit_0 = valid_bits[0][req_index] && (tags[0][req_index] == req_tag);
  assign hit_1 = valid_bits[1][req_index] && (tags[1][req_index] == req_tag);

  assign dirty_0 = dirty_bits[0][req_index];
  assign dirty_1 = dirty_bits[1][req_index];
  assign lru     = lru_bits[req_index];

  // Stored tag of the selected way, used for the write-back address
  assign victim_tag = tags[way][req_index];

endmodule

`default_nettype wire

//--- src/cache_ctrl.sv
/* Cache controller FSM with registered hit flags, way choice,
   LRU update and the processor and memory handshakes */

`timescale 1ns/100ps
`default_nettype none

module cache_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_val,
  output logic               req_rdy,
  output logic               resp_val,
  input  logic               resp_rdy,
  output logic               mem_req_val,
  input  logic               mem_req_rdy,
  input  logic               mem_resp_val,
  output logic               mem_resp_rdy,
  output logic               mem_write,
  input  cache_pkg::mem_op_t req_type,
  input  logic               hit_0,
  input  logic               hit_1,
  input  logic               dirty_0,
  input  logic               dirty_1,
  input  logic               lru,
  output logic               req_en,
  output logic               tag_write,
  output logic               dirty_in,
  output logic               lru_write,
  output logic               lru_in,
  output logic               way,
  output logic               data_read,
  output logic               data_write,
  output logic               fill_from_mem,
  output logic               read_capture,
  output logic               evict_select,
  output logic               resp_zero
);
  import cache_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        hit_0_q;
  logic        hit_1_q;
  logic        hit_now;
  logic        victim_dirty;

  assign hit_now      = hit_0 | hit_1;
  // lru names the way to replace
  assign victim_dirty = lru ? dirty_1 : dirty_0;

  // ----------------------------------------
  // State and hit flag registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      hit_0_q <= 1'b0;
      hit_1_q <= 1'b0;
    end else if (state == ST_TAG_CHECK) begin
      hit_0_q <= hit_0;
      hit_1_q <= hit_1;
    end
  end

  // Hit way on a hit, victim way on a miss
  assign way      = (hit_0_q | hit_1_q) ? hit_1_q : lru;
  assign lru_in   = ~way;
  assign dirty_in = (state == ST_WRITE_ACCESS);

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (req_val) state_next = ST_TAG_CHECK;
      end
      ST_TAG_CHECK: begin
        if (req_type == OP_INIT) begin
          state_next = ST_INIT_ACCESS;
        end else if (hit_now) begin
          state_next = (req_type == OP_WRITE) ? ST_WRITE_ACCESS : ST_READ_ACCESS;
        end else if (victim_dirty) begin
          state_next = ST_EVICT_PREP;
        end else begin
          state_next = ST_REFILL_REQ;
        end
      end
      ST_INIT_ACCESS,
      ST_READ_ACCESS,
      ST_WRITE_ACCESS:  state_next = ST_RESP;
      ST_REFILL_REQ: begin
        if (mem_req_rdy) state_next = ST_REFILL_WAIT;
      end
      ST_REFILL_WAIT: begin
        if (mem_resp_val) state_next = ST_REFILL_UPDATE;
      end
      ST_REFILL_UPDATE: begin
        state_next = (req_type == OP_WRITE) ? ST_WRITE_ACCESS : ST_READ_ACCESS;
      end
      ST_EVICT_PREP:    state_next = ST_EVICT_REQ;
      ST_EVICT_REQ: begin
        if (mem_req_rdy) state_next = ST_EVICT_WAIT;
      end
      ST_EVICT_WAIT: begin
        // Write-back acknowledged, fetch the new line
        if (mem_resp_val) state_next = ST_REFILL_REQ;
      end
      ST_RESP: begin
        if (resp_rdy) state_next = ST_IDLE;
      end
      default:          state_next = ST_IDLE;
    endcase
  end

  // ----------------------------------------
  // Control outputs per state
  // ----------------------------------------
  always_comb begin
    req_rdy       = 1'b0;
    req_en        = 1'b0;
    resp_val      = 1'b0;
    mem_req_val   = 1'b0;
    mem_resp_rdy  = 1'b0;
    mem_write     = 1'b0;
    tag_write     = 1'b0;
    lru_write     = 1'b0;
    data_read     = 1'b0;
    data_write    = 1'b0;
    fill_from_mem = 1'b0;
    read_capture  = 1'b0;
    evict_select  = 1'b0;
    resp_zero     = 1'b0;
    case (state)
      ST_IDLE: begin
        req_rdy = 1'b1;
        req_en  = req_val;
      end
      ST_INIT_ACCESS: begin
        tag_write    = 1'b1;
        data_write   = 1'b1;
        read_capture = 1'b1;
        resp_zero    = 1'b1;
      end
      ST_READ_ACCESS: begin
        data_read    = 1'b1;
        read_capture = 1'b1;
        lru_write    = 1'b1;
      end
      ST_WRITE_ACCESS: begin
        tag_write    = 1'b1;
        data_write   = 1'b1;
        lru_write    = 1'b1;
        read_capture = 1'b1;
        resp_zero    = 1'b1;
      end
      ST_REFILL_REQ:    mem_req_val = 1'b1;
      ST_REFILL_UPDATE: begin
        // Memory holds valid here, data lands as it is accepted
        mem_resp_rdy  = 1'b1;
        tag_write     = 1'b1;
        data_write    = 1'b1;
        fill_from_mem = 1'b1;
      end
      ST_EVICT_PREP: begin
        data_read    = 1'b1;
        read_capture = 1'b1;
        evict_select = 1'b1;
      end
      ST_EVICT_REQ: begin
        mem_req_val  = 1'b1;
        mem_write    = 1'b1;
        evict_select = 1'b1;
      end
      ST_EVICT_WAIT: begin
        mem_resp_rdy = 1'b1;
        evict_select = 1'b1;
      end
      ST_RESP:          resp_val = 1'b1;
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/cache_pkg.sv
/* Shared types of the cache: request opcodes and controller states */

`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

  // Request kinds, used on processor and memory ports
  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_INIT  = 2'd2
  } mem_op_t;

  typedef enum logic [3:0] {
    ST_IDLE          = 4'd0,
    ST_TAG_CHECK     = 4'd1,
    ST_INIT_ACCESS   = 4'd2,
    ST_READ_ACCESS   = 4'd3,
    ST_WRITE_ACCESS  = 4'd4,
    ST_REFILL_REQ    = 4'd5,
    ST_REFILL_WAIT   = 4'd6,
    ST_REFILL_UPDATE = 4'd7,
    ST_EVICT_PREP    = 4'd8,
    ST_EVICT_REQ     = 4'd9,
    ST_EVICT_WAIT    = 4'd10,
    ST_RESP          = 4'd11
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/cache_cfg.svh
/* Address, data and set geometry of the two-way data cache */

`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// ----------------------------------------
// Word and address sizes
// ----------------------------------------
`define CACHE_ADDR_W 32
`define CACHE_DATA_W 32

// ----------------------------------------
// Set geometry, one word per line
// ----------------------------------------
`define CACHE_NUM_SETS 8
// Index sits just above the 2-bit byte offset
`define CACHE_INDEX_W 3
`define CACHE_TAG_W 27

`endif
